//--- mips_macros.svh
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// data word width
`define MIPS_XLEN 32

// instruction memory word address width, 256 words
`define MIPS_IMEM_AW 8

// data memory word address width
`define MIPS_DMEM_AW 8

// jal writes its link address here
`define MIPS_RA_REG 31

`endif

//--- mips_pkg.sv
`default_nettype none

package mips_pkg;

  // primary opcode, instr[31:26]
  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_J     = 6'h02,
    OP_JAL   = 6'h03,
    OP_BEQ   = 6'h04,
    OP_BNE   = 6'h05,
    OP_ADDI  = 6'h08,
    OP_SLTI  = 6'h0a,
    OP_ANDI  = 6'h0c,
    OP_ORI   = 6'h0d,
    OP_LW    = 6'h23,
    OP_SW    = 6'h2b
  } opcode_t;

  // r-type function field, instr[5:0]
  typedef enum logic [5:0] {
    FN_JR  = 6'h08,
    FN_ADD = 6'h20,
    FN_SUB = 6'h22,
    FN_AND = 6'h24,
    FN_OR  = 6'h25,
    FN_SLT = 6'h2a
  } funct_t;

  typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT} alu_op_t;

  // write-back source
  typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_LINK} wb_sel_t;

  // destination register: rt for i-type, rd for r-type, ra for jal
  typedef enum logic [1:0] {DST_RT, DST_RD, DST_RA} dst_sel_t;

  typedef struct packed {
    logic     reg_wen;  // register file write
    dst_sel_t dst_sel;
    logic     imm_b;    // operand b from the extender
    logic     sign_ext; // 0 means zero extend
    alu_op_t  alu_op;
    logic     mem_wen;  // sw
    wb_sel_t  wb_sel;
    logic     beq;
    logic     bne;
    logic     jump;     // j, jal
    logic     jreg;     // jr
  } ctrl_t;

endpackage

`default_nettype wire

//--- mips_ifs.sv
`default_nettype none

`include "mips_macros.svh"

// fetch side to execute, one cycle of level logic
interface fetch_if;
  logic [`MIPS_XLEN-1:0] instr;       // word at the pc
  logic [`MIPS_XLEN-1:0] pc_plus4;
  logic                  redirect_en; // taken branch or jump
  logic [`MIPS_XLEN-1:0] redirect_pc;

  modport fetch (
    output instr, pc_plus4,
    input  redirect_en, redirect_pc
  );

  modport exec (
    input  instr, pc_plus4,
    output redirect_en, redirect_pc
  );
endinterface

// execute to data memory and back for write-back
interface mem_if;
  import mips_pkg::*;

  logic [`MIPS_XLEN-1:0] alu_res;  // also the byte address
  logic [`MIPS_XLEN-1:0] st_data;  // rt value
  logic                  mem_wen;
  wb_sel_t               wb_sel;
  logic [`MIPS_XLEN-1:0] link_adr; // pc+4 for jal
  logic [`MIPS_XLEN-1:0] wb_data;  // selected result

  modport exec (output alu_res, st_data, mem_wen, wb_sel, link_adr, input wb_data);
  modport mem  (input alu_res, st_data, mem_wen, wb_sel, link_adr, output wb_data);
endinterface

`default_nettype wire

//--- fetch_unit.sv
`default_nettype none

`include "mips_macros.svh"

module fetch_unit #(
  parameter int IMEM_AW = `MIPS_IMEM_AW
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  imem_wen,   // program load strobe
  input  logic [IMEM_AW-1:0]    imem_adr,   // word address
  input  logic [`MIPS_XLEN-1:0] imem_wdata,
  fetch_if.fetch                fch
);

  localparam int IMEM_DEPTH = 2 ** IMEM_AW;

  logic [`MIPS_XLEN-1:0] pc;
  logic [`MIPS_XLEN-1:0] pc_next;
  logic [`MIPS_XLEN-1:0] pc_plus4;
  logic [IMEM_AW-1:0]    fetch_adr;

  // instruction store, no reset on contents
  logic [`MIPS_XLEN-1:0] imem [IMEM_DEPTH];

  // load port, usable while rst is held
  always_ff @(posedge clk) begin
    if (imem_wen) begin
      imem[imem_adr] <= imem_wdata;
    end
  end

  // byte pc to word index
  assign fetch_adr = pc[IMEM_AW+1:2];
  assign pc_plus4  = pc + `MIPS_XLEN'(4);

  // combinational read
  assign fch.instr    = imem[fetch_adr];
  assign fch.pc_plus4 = pc_plus4;

  // redirect wins over sequential
  always_comb begin
    if (fch.redirect_en) begin
      pc_next = fch.redirect_pc;
    end else begin
      pc_next = pc_plus4;
    end
  end

  // pc sits at 0 through reset so the
  // first instruction after reset is word 0
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else begin
      pc <= pc_next; // one instruction retires per edge
    end
  end

endmodule

`default_nettype wire

//--- reg_file.sv
`default_nettype none

`include "mips_macros.svh"

module reg_file (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [4:0]            ra_adr,  // rs
  input  logic [4:0]            rb_adr,  // rt
  output logic [`MIPS_XLEN-1:0] ra_data,
  output logic [`MIPS_XLEN-1:0] rb_data,
  input  logic                  wr_en,
  input  logic [4:0]            wr_adr,
  input  logic [`MIPS_XLEN-1:0] wr_data
);

  logic [`MIPS_XLEN-1:0] regs [32];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && (wr_adr != 5'd0)) begin // $zero ignores writes
      regs[wr_adr] <= wr_data;
    end
  end

  // async read, $zero forced
  assign ra_data = (ra_adr == 5'd0) ? '0 : regs[ra_adr];
  assign rb_data = (rb_adr == 5'd0) ? '0 : regs[rb_adr];

endmodule

`default_nettype wire

//--- exec_core.sv
`default_nettype none

`include "mips_macros.svh"

module exec_core (
  input  logic  clk,
  input  logic  rst,
  fetch_if.exec fch,
  mem_if.exec   mem
);

  import mips_pkg::*;

  // instruction fields
  opcode_t     opcode;
  funct_t      funct;
  logic [4:0]  rs;
  logic [4:0]  rt;
  logic [4:0]  rd;
  logic [15:0] imm;
  logic [25:0] jidx;

  ctrl_t ctrl;

  logic [`MIPS_XLEN-1:0] rs_data;
  logic [`MIPS_XLEN-1:0] rt_data;
  logic [`MIPS_XLEN-1:0] imm_ext;
  logic [`MIPS_XLEN-1:0] opb;
  logic [`MIPS_XLEN-1:0] alu_res;
  logic [`MIPS_XLEN-1:0] br_target;
  logic [`MIPS_XLEN-1:0] j_target;
  logic [4:0]            wr_adr;
  logic                  br_taken;

  assign opcode = opcode_t'(fch.instr[31:26]);
  assign rs     = fch.instr[25:21];
  assign rt     = fch.instr[20:16];
  assign rd     = fch.instr[15:11];
  assign funct  = funct_t'(fch.instr[5:0]);
  assign imm    = fch.instr[15:0];
  assign jidx   = fch.instr[25:0];

  // controller
  // unknown encodings fall out as a nop
  always_comb begin
    ctrl          = '0;
    ctrl.sign_ext = 1'b1;
    ctrl.alu_op   = ALU_ADD;
    ctrl.wb_sel   = WB_ALU;
    case (opcode)
      OP_RTYPE: begin
        ctrl.dst_sel = DST_RD;
        ctrl.reg_wen = 1'b1;
        case (funct)
          FN_ADD:  ctrl.alu_op = ALU_ADD;
          FN_SUB:  ctrl.alu_op = ALU_SUB;
          FN_AND:  ctrl.alu_op = ALU_AND;
          FN_OR:   ctrl.alu_op = ALU_OR;
          FN_SLT:  ctrl.alu_op = ALU_SLT;
          FN_JR: begin
            ctrl.reg_wen = 1'b0;
            ctrl.jreg    = 1'b1; // target from rs
          end
          default: ctrl.reg_wen = 1'b0;
        endcase
      end
      OP_ADDI: begin
        ctrl.reg_wen = 1'b1;
        ctrl.imm_b   = 1'b1;
      end
      OP_SLTI: begin
        ctrl.reg_wen = 1'b1;
        ctrl.imm_b   = 1'b1;
        ctrl.alu_op  = ALU_SLT;
      end
      OP_ANDI: begin
        ctrl.reg_wen  = 1'b1;
        ctrl.imm_b    = 1'b1;
        ctrl.sign_ext = 1'b0; // logical imm zero extends
        ctrl.alu_op   = ALU_AND;
      end
      OP_ORI: begin
        ctrl.reg_wen  = 1'b1;
        ctrl.imm_b    = 1'b1;
        ctrl.sign_ext = 1'b0;
        ctrl.alu_op   = ALU_OR;
      end
      OP_LW: begin
        ctrl.reg_wen = 1'b1;
        ctrl.imm_b   = 1'b1;
        ctrl.wb_sel  = WB_MEM;
      end
      OP_SW: begin
        ctrl.imm_b   = 1'b1;
        ctrl.mem_wen = 1'b1;
      end
      OP_BEQ: ctrl.beq  = 1'b1;
      OP_BNE: ctrl.bne  = 1'b1;
      OP_J:   ctrl.jump = 1'b1;
      OP_JAL: begin
        ctrl.jump    = 1'b1;
        ctrl.reg_wen = 1'b1;
        ctrl.dst_sel = DST_RA;
        ctrl.wb_sel  = WB_LINK;
      end
      default: ;
    endcase
  end

  reg_file u_rf (
    .clk     (clk),
    .rst     (rst),
    .ra_adr  (rs),
    .rb_adr  (rt),
    .ra_data (rs_data),
    .rb_data (rt_data),
    .wr_en   (ctrl.reg_wen),
    .wr_adr  (wr_adr),
    .wr_data (mem.wb_data) // back from mem_stage
  );

  // extender
  assign imm_ext = ctrl.sign_ext ? {{(`MIPS_XLEN-16){imm[15]}}, imm}
                                 : {{(`MIPS_XLEN-16){1'b0}}, imm};
  assign opb     = ctrl.imm_b ? imm_ext : rt_data;

  // alu
  always_comb begin
    case (ctrl.alu_op)
      ALU_SUB: alu_res = rs_data - opb;
      ALU_AND: alu_res = rs_data & opb;
      ALU_OR:  alu_res = rs_data | opb;
      ALU_SLT: alu_res = `MIPS_XLEN'($signed(rs_data) < $signed(opb));
      default: alu_res = rs_data + opb;
    endcase
  end

  // branch and jump resolution
  assign br_taken  = (ctrl.beq && (rs_data == rt_data)) ||
                     (ctrl.bne && (rs_data != rt_data));
  assign br_target = fch.pc_plus4 + {imm_ext[`MIPS_XLEN-3:0], 2'b00};
  assign j_target  = {fch.pc_plus4[`MIPS_XLEN-1:28], jidx, 2'b00}; // pseudo-direct

  assign fch.redirect_en = br_taken || ctrl.jump || ctrl.jreg;
  always_comb begin
    if (ctrl.jreg)      fch.redirect_pc = rs_data;
    else if (ctrl.jump) fch.redirect_pc = j_target;
    else                fch.redirect_pc = br_target;
  end

  // destination mux
  always_comb begin
    case (ctrl.dst_sel)
      DST_RD:  wr_adr = rd;
      DST_RA:  wr_adr = 5'(`MIPS_RA_REG);
      default: wr_adr = rt;
    endcase
  end

  assign mem.alu_res  = alu_res;
  assign mem.st_data  = rt_data;
  assign mem.mem_wen  = ctrl.mem_wen;
  assign mem.wb_sel   = ctrl.wb_sel;
  assign mem.link_adr = fch.pc_plus4; // return point for jal

endmodule

`default_nettype wire

//--- mem_stage.sv
`default_nettype none

`include "mips_macros.svh"

module mem_stage #(
  parameter int DMEM_AW = `MIPS_DMEM_AW
) (
  input  logic                  clk,
  input  logic                  rst,
  mem_if.mem                    mem,
  output logic                  st_wen,   // store strobe
  output logic [`MIPS_XLEN-1:0] st_adr,   // byte address
  output logic [`MIPS_XLEN-1:0] st_wdata
);

  import mips_pkg::*;

  localparam int DMEM_DEPTH = 2 ** DMEM_AW;

  logic [`MIPS_XLEN-1:0] dmem [DMEM_DEPTH]; // word organised
  logic [DMEM_AW-1:0]    word_adr;
  logic [`MIPS_XLEN-1:0] ld_data;
  logic                  store;

  assign word_adr = mem.alu_res[DMEM_AW+1:2]; // low two bits dropped

  // pc is pinned at 0 during reset and imem
  // may hold a sw there, keep the store quiet
  assign store = mem.mem_wen && !rst;

  always_ff @(posedge clk) begin
    if (store) begin
      dmem[word_adr] <= mem.st_data;
    end
  end

  assign ld_data = dmem[word_adr]; // combinational load

  // mirror of the memory write
  assign st_wen   = store;
  assign st_adr   = mem.alu_res;
  assign st_wdata = mem.st_data;

  // write-back select
  always_comb begin
    case (mem.wb_sel)
      WB_MEM:  mem.wb_data = ld_data;
      WB_LINK: mem.wb_data = mem.link_adr;
      default: mem.wb_data = mem.alu_res; // WB_ALU
    endcase
  end

endmodule

`default_nettype wire

//--- mips_cpu.sv
`default_nettype none

`include "mips_macros.svh"

module mips_cpu (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     imem_wen,
  input  logic [`MIPS_IMEM_AW-1:0] imem_adr,
  input  logic [`MIPS_XLEN-1:0]    imem_wdata,
  output logic                     st_wen,
  output logic [`MIPS_XLEN-1:0]    st_adr,
  output logic [`MIPS_XLEN-1:0]    st_wdata
);

  fetch_if fch (); // instr and pc+4 out, redirect back
  mem_if   mem (); // alu result and ctrl out, wb data back

  // input side
  fetch_unit #(.IMEM_AW(`MIPS_IMEM_AW)) u_fetch (
    .clk        (clk),
    .rst        (rst),
    .imem_wen   (imem_wen),
    .imem_adr   (imem_adr),
    .imem_wdata (imem_wdata),
    .fch        (fch.fetch)
  );

  // decode, register file, alu, branch
  exec_core u_exec (
    .clk (clk),
    .rst (rst),
    .fch (fch.exec),
    .mem (mem.exec)
  );

  // data memory and write-back
  mem_stage #(.DMEM_AW(`MIPS_DMEM_AW)) u_mem (
    .clk      (clk),
    .rst      (rst),
    .mem      (mem.mem),
    .st_wen   (st_wen),
    .st_adr   (st_adr),
    .st_wdata (st_wdata)
  );

endmodule

`default_nettype wire

//--- cpu_chk.sv
`default_nettype none

`include "mips_macros.svh"

module cpu_chk (
  input logic                  clk,
  input logic                  rst,
  input logic                  st_wen,
  input logic [`MIPS_XLEN-1:0] st_adr,
  input logic [`MIPS_XLEN-1:0] pc
);

  timeunit 1ns;
  timeprecision 100ps;

  // pc sits on word 0 under reset, a sw there must stay quiet
  a_quiet_in_rst: assert property (@(posedge clk) rst |-> !st_wen)
    else $error("st_wen high while rst is high");

  a_st_aligned: assert property (@(posedge clk) st_wen |-> (st_adr[1:0] == 2'b00))
    else $error("store address %h not word aligned", st_adr); // word access only

  // first cycle out of reset runs word 0
  a_pc_start: assert property (@(posedge clk) (!rst && $past(rst)) |-> (pc == '0))
    else $error("pc is %h in the first cycle after reset", pc);

endmodule

bind mips_cpu cpu_chk u_chk (
  .clk    (clk),
  .rst    (rst),
  .st_wen (st_wen),
  .st_adr (st_adr),
  .pc     (u_fetch.pc)
);

`default_nettype wire

//--- cpu_tb.sv
`default_nettype none

`include "mips_macros.svh"

module cpu_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD = 8;
  localparam int RST_CYCLES = 4;
  localparam int NPROG      = 41; // program words
  localparam int NST        = 16; // expected stores in order
  localparam int DRAIN      = 10; // quiet cycles before the pass
  // load, reset, then the program length plus 50 cycles to run
  localparam int RUN_LIMIT  = (NPROG + 1 + RST_CYCLES + NPROG + 50) * CLK_PERIOD;

  logic                     clk;
  logic                     rst;
  logic                     imem_wen;
  logic [`MIPS_IMEM_AW-1:0] imem_adr;
  logic [`MIPS_XLEN-1:0]    imem_wdata;
  logic                     st_wen;
  logic [`MIPS_XLEN-1:0]    st_adr;
  logic [`MIPS_XLEN-1:0]    st_wdata;

  logic [31:0] prog     [NPROG]; // instruction words
  logic [31:0] exp_adr  [NST];
  logic [31:0] exp_data [NST];
  int          n_seen;           // stores matched so far

  mips_cpu uut (
    .clk        (clk),
    .rst        (rst),
    .imem_wen   (imem_wen),
    .imem_adr   (imem_adr),
    .imem_wdata (imem_wdata),
    .st_wen     (st_wen),
    .st_adr     (st_adr),
    .st_wdata   (st_wdata)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // mips encodings straight from the isa field layout
  function automatic logic [31:0] rtype_word(input logic [4:0] rs, input logic [4:0] rt,
                                             input logic [4:0] rd, input logic [5:0] fn);
    return {6'h00, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] jtype_word(input logic [5:0] op, input logic [25:0] idx);
    return {op, idx};
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [31:0] expv,
                           input logic [31:0] actv);
    if (actv !== expv) begin
      abort_run($sformatf("** Error at %0d ns: %s expected %h, got %h",
                          $time, name, expv, actv));
    end
  endtask

  task automatic add_store_row(input int idx, input logic [31:0] adr, input logic [31:0] data);
    exp_adr[idx]  = adr;
    exp_data[idx] = data;
  endtask

  task automatic build_tables();
    logic [31:0] s;
    logic [15:0] ia, ib, ic;
    logic [31:0] va, vb, vcs, vcz;
    s   = lcg_step(32'd49304);
    ia  = {1'b1, s[30:16]}; // forced negative
    s   = lcg_step(s);
    ib  = {1'b0, s[30:16]}; // forced positive
    s   = lcg_step(s);
    ic  = {1'b1, s[30:16]}; // negative so sign and zero extend differ
    va  = {{16{ia[15]}}, ia};
    vb  = {{16{ib[15]}}, ib};
    vcs = {{16{ic[15]}}, ic};
    vcz = {16'h0000, ic};
    prog[0]  = itype_word(6'h08, 5'd0, 5'd1, ia);      // addi $1, $0, ia
    prog[1]  = itype_word(6'h08, 5'd0, 5'd2, ib);      // addi $2, $0, ib
    prog[2]  = rtype_word(5'd1, 5'd2, 5'd3, 6'h20);    // add $3, $1, $2
    prog[3]  = itype_word(6'h2b, 5'd0, 5'd3, 16'd0);   // sw $3, 0
    prog[4]  = rtype_word(5'd1, 5'd2, 5'd3, 6'h22);    // sub
    prog[5]  = itype_word(6'h2b, 5'd0, 5'd3, 16'd4);
    prog[6]  = rtype_word(5'd1, 5'd2, 5'd3, 6'h24);    // and
    prog[7]  = itype_word(6'h2b, 5'd0, 5'd3, 16'd8);
    prog[8]  = rtype_word(5'd1, 5'd2, 5'd3, 6'h25);    // or
    prog[9]  = itype_word(6'h2b, 5'd0, 5'd3, 16'd12);
    prog[10] = rtype_word(5'd1, 5'd2, 5'd3, 6'h2a);    // slt
    prog[11] = itype_word(6'h2b, 5'd0, 5'd3, 16'd16);
    prog[12] = itype_word(6'h0c, 5'd1, 5'd4, ic);      // andi $4, $1, ic
    prog[13] = itype_word(6'h2b, 5'd0, 5'd4, 16'd20);
    prog[14] = itype_word(6'h0d, 5'd2, 5'd4, ic);      // ori $4, $2, ic
    prog[15] = itype_word(6'h2b, 5'd0, 5'd4, 16'd24);
    prog[16] = itype_word(6'h0a, 5'd1, 5'd4, ic);      // slti $4, $1, ic
    prog[17] = itype_word(6'h2b, 5'd0, 5'd4, 16'd28);
    prog[18] = itype_word(6'h08, 5'd1, 5'd5, ic);      // addi $5, $1, ic
    prog[19] = itype_word(6'h2b, 5'd0, 5'd5, 16'd32);
    prog[20] = itype_word(6'h2b, 5'd0, 5'd1, 16'd64);  // sw $1, 64
    prog[21] = itype_word(6'h23, 5'd0, 5'd6, 16'd64);  // lw $6, 64
    prog[22] = itype_word(6'h2b, 5'd0, 5'd6, 16'd68);  // same data again
    prog[23] = itype_word(6'h04, 5'd1, 5'd1, 16'd1);   // beq taken
    prog[24] = itype_word(6'h2b, 5'd0, 5'd1, 16'd128); // skipped
    prog[25] = itype_word(6'h05, 5'd1, 5'd1, 16'd1);   // bne falls through
    prog[26] = itype_word(6'h2b, 5'd0, 5'd2, 16'd72);
    prog[27] = itype_word(6'h05, 5'd1, 5'd2, 16'd1);   // bne taken
    prog[28] = itype_word(6'h2b, 5'd0, 5'd1, 16'd132); // skipped
    prog[29] = itype_word(6'h04, 5'd1, 5'd2, 16'd1);   // beq falls through
    prog[30] = itype_word(6'h2b, 5'd0, 5'd5, 16'd76);
    prog[31] = jtype_word(6'h02, 26'd33);              // j 33
    prog[32] = itype_word(6'h2b, 5'd0, 5'd1, 16'd136); // skipped
    prog[33] = jtype_word(6'h03, 26'd38);              // jal 38 with link 136
    prog[34] = itype_word(6'h2b, 5'd0, 5'd31, 16'd80); // return point
    prog[35] = itype_word(6'h08, 5'd1, 5'd0, ib);      // write to $0 gets dropped
    prog[36] = itype_word(6'h2b, 5'd0, 5'd0, 16'd84);
    prog[37] = jtype_word(6'h02, 26'd37);              // spin here
    prog[38] = itype_word(6'h08, 5'd0, 5'd7, ib);      // subroutine
    prog[39] = itype_word(6'h2b, 5'd0, 5'd7, 16'd88);
    prog[40] = rtype_word(5'd31, 5'd0, 5'd0, 6'h08);   // jr $31
    add_store_row(0, 32'd0, va + vb);
    add_store_row(1, 32'd4, va - vb);
    add_store_row(2, 32'd8, va & vb);
    add_store_row(3, 32'd12, va | vb);
    add_store_row(4, 32'd16, {31'd0, $signed(va) < $signed(vb)});
    add_store_row(5, 32'd20, va & vcz);
    add_store_row(6, 32'd24, vb | vcz);
    add_store_row(7, 32'd28, {31'd0, $signed(va) < $signed(vcs)});
    add_store_row(8, 32'd32, va + vcs);
    add_store_row(9, 32'd64, va);
    add_store_row(10, 32'd68, va);
    add_store_row(11, 32'd72, vb);
    add_store_row(12, 32'd76, va + vcs);
    add_store_row(13, 32'd88, vb);   // subroutine runs first
    add_store_row(14, 32'd80, 32'd136);
    add_store_row(15, 32'd84, 32'd0);
  endtask

  initial begin
    rst        = 1'b1;
    imem_wen   = 1'b0;
    imem_adr   = '0;
    imem_wdata = '0;
    n_seen     = 0;
    build_tables();
    // one word per cycle with rst held throughout
    for (int i = 0; i < NPROG; i++) begin
      @(posedge clk);
      #1;
      imem_wen   = 1'b1;
      imem_adr   = `MIPS_IMEM_AW'(i);
      imem_wdata = prog[i];
    end
    @(posedge clk);
    #1;
    imem_wen = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
    wait (n_seen == NST);
    repeat (DRAIN) @(posedge clk); // any extra store from the spin loop trips the monitor
    #1;
    $display("No errors");
    $finish;
  end

  // store monitor sees the values of the cycle the edge closes
  always @(posedge clk) begin
    if (st_wen) begin
      if (n_seen >= NST) begin
        abort_run($sformatf("unexpected store to address %h after all expected stores",
                            st_adr));
      end else begin
        check_val("st_adr", exp_adr[n_seen], st_adr);
        check_val("st_wdata", exp_data[n_seen], st_wdata);
        n_seen = n_seen + 1;
      end
    end
  end

  // watchdog
  initial begin
    #(RUN_LIMIT);
    abort_run($sformatf("timeout, only %0d of %0d expected stores seen", n_seen, NST));
  end

endmodule

`default_nettype wire

//--- list.f
+incdir+.
mips_pkg.sv
mips_ifs.sv
fetch_unit.sv
reg_file.sv
exec_core.sv
mem_stage.sv
mips_cpu.sv
cpu_chk.sv
cpu_tb.sv

//--- run.sh
#!/bin/sh
# build and run the cpu testbench with verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module cpu_tb -f list.f -o cpu_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/cpu_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Errors found" "$LOG"; then
  echo "FAIL"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "FAIL: simulation exited with status $sim_status"
  exit 1
fi
echo "PASS"
exit 0
